// ==== common/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

`default_nettype none

// Memory geometry shared by the RAM, the arbiter and the fill engine
`define MEM_DATA_W  32          // Word width, four byte lanes
`define MEM_ADDR_W  10          // Word address width
`define MEM_DEPTH   1024        // Number of words
`define MEM_SEL_W   4           // One select bit per byte lane

`default_nettype wire

`endif

// ==== common/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // Port A arbiter FSM
    typedef enum logic [1:0] {
        arb_idle   = 2'd0,      // No access in flight
        arb_access = 2'd1,      // RAM port A enabled for the granted master
        arb_ack    = 2'd2       // Read data valid and ack to the granted master
    } arb_state_e;

    // Granted master, the host is 0 and the fill engine is 1
    typedef logic master_idx_t;

endpackage

`default_nettype wire

// ==== common/fill_pkg.sv ====
`default_nettype none

package fill_pkg;

    // Command opcodes
    typedef enum logic {
        op_fill = 1'b0,         // Write pattern plus offset over a range
        op_sum  = 1'b1          // Add up a range through port B
    } fill_op_e;

    // Engine FSM
    typedef enum logic [1:0] {
        fs_idle  = 2'd0,        // Ready for a command
        fs_write = 2'd1,        // Wishbone writes in progress
        fs_sum   = 2'd2,        // Port B reads and accumulation
        fs_done  = 2'd3         // One-cycle completion pulse
    } fill_state_e;

endpackage

`default_nettype wire

// ==== memory/dpram.sv ====
`timescale 1ns/1ps
`default_nettype none

module dpram #(
    parameter int ram_width = 32,                     // Word width, split into four lanes
    parameter int ram_depth = 1024                    // Number of words
) (
    input  logic                         clka,
    // Port A
    input  logic                         ena,         // Port enable
    input  logic                         wea,         // Write enable
    input  logic [3:0]                   wema,        // Byte lane mask
    input  logic [$clog2(ram_depth)-1:0] addra,
    input  logic [ram_width-1:0]         dina,
    output logic [ram_width-1:0]         douta,       // Registered read data
    // Port B
    input  logic                         enb,
    input  logic                         web,
    input  logic [3:0]                   wemb,
    input  logic [$clog2(ram_depth)-1:0] addrb,
    input  logic [ram_width-1:0]         dinb,
    output logic [ram_width-1:0]         doutb
);

    localparam int lanes  = 4;                        // Byte lanes per word
    localparam int lane_w = ram_width / lanes;        // Bits per lane

    logic [ram_width-1:0] mem [ram_depth];            // Storage array

    // Both ports share one process so the array has a single writer.
    // Reads return the contents from before this edge's writes.
    always_ff @(posedge clka) begin
        if (ena)
            douta <= mem[addra];                      // One-cycle read, port A
        if (enb)
            doutb <= mem[addrb];                      // One-cycle read, port B
        for (int i = 0; i < lanes; i++) begin
            if (ena && wea && wema[i])
                mem[addra][i*lane_w +: lane_w] <= dina[i*lane_w +: lane_w];
            if (enb && web && wemb[i])
                mem[addrb][i*lane_w +: lane_w] <= dinb[i*lane_w +: lane_w];
        end
    end

endmodule

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module wb_arbiter (
    input  logic                   clka,
    input  logic                   rsta,
    // Master 0, the host
    input  logic                   m0_cyc,
    input  logic                   m0_stb,
    input  logic                   m0_we,
    input  logic [`MEM_ADDR_W-1:0] m0_adr,
    input  logic [`MEM_SEL_W-1:0]  m0_sel,
    input  logic [`MEM_DATA_W-1:0] m0_dat_w,
    output logic [`MEM_DATA_W-1:0] m0_dat_r,
    output logic                   m0_ack,
    // Master 1, the fill engine
    input  logic                   m1_cyc,
    input  logic                   m1_stb,
    input  logic                   m1_we,
    input  logic [`MEM_ADDR_W-1:0] m1_adr,
    input  logic [`MEM_SEL_W-1:0]  m1_sel,
    input  logic [`MEM_DATA_W-1:0] m1_dat_w,
    output logic [`MEM_DATA_W-1:0] m1_dat_r,
    output logic                   m1_ack,
    // RAM port A
    output logic                   ram_a_en,
    output logic                   ram_a_we,
    output logic [`MEM_SEL_W-1:0]  ram_a_sel,
    output logic [`MEM_ADDR_W-1:0] ram_a_adr,
    output logic [`MEM_DATA_W-1:0] ram_a_dat_w,
    input  logic [`MEM_DATA_W-1:0] ram_a_dat_r
);

    import wb_pkg::*;

    arb_state_e  state;            // Arbiter FSM
    master_idx_t last_grant;       // Owner of the current or most recent access
    master_idx_t pick;             // Winner of this cycle's arbitration
    logic        grant_now;        // A new access starts next cycle
    logic        req0;
    logic        req1;

    assign req0 = m0_cyc & m0_stb; // Classic cycle request
    assign req1 = m1_cyc & m1_stb;

    always_comb begin
        grant_now = 1'b0;
        pick      = last_grant;
        case (state)
            arb_idle: begin
                grant_now = req0 | req1;
                if (req0 && req1)
                    pick = ~last_grant;          // Round-robin on a tie
                else if (req1)
                    pick = master_idx_t'(1);
                else
                    pick = master_idx_t'(0);
            end
            arb_ack: begin
                // The owner still holds stb this cycle, so only the other master may
                // follow straight on without a pass through idle
                if (last_grant == master_idx_t'(0)) begin
                    grant_now = req1;
                    pick      = master_idx_t'(1);
                end else begin
                    grant_now = req0;
                    pick      = master_idx_t'(0);
                end
            end
            default: begin
                grant_now = 1'b0;                // Access in flight
            end
        endcase
    end

    always_ff @(posedge clka) begin
        if (rsta) begin
            state      <= arb_idle;
            last_grant <= master_idx_t'(1);      // Host wins the first tie
        end else begin
            case (state)
                arb_idle:   state <= grant_now ? arb_access : arb_idle;
                arb_access: state <= arb_ack;
                arb_ack:    state <= grant_now ? arb_access : arb_idle;
                default:    state <= arb_idle;
            endcase
            if (grant_now)
                last_grant <= pick;
        end
    end

    // Request latched into port A for the access cycle
    always_ff @(posedge clka) begin
        if (grant_now) begin
            ram_a_we    <= (pick == master_idx_t'(1)) ? m1_we    : m0_we;
            ram_a_sel   <= (pick == master_idx_t'(1)) ? m1_sel   : m0_sel;
            ram_a_adr   <= (pick == master_idx_t'(1)) ? m1_adr   : m0_adr;
            ram_a_dat_w <= (pick == master_idx_t'(1)) ? m1_dat_w : m0_dat_w;
        end
    end

    assign ram_a_en = (state == arb_access);                             // One cycle per grant

    assign m0_ack   = (state == arb_ack) && (last_grant == master_idx_t'(0));
    assign m1_ack   = (state == arb_ack) && (last_grant == master_idx_t'(1));
    assign m0_dat_r = (last_grant == master_idx_t'(0)) ? ram_a_dat_r : '0; // Owner only
    assign m1_dat_r = (last_grant == master_idx_t'(1)) ? ram_a_dat_r : '0;

endmodule

`default_nettype wire

// ==== logic/fill_engine.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module fill_engine (
    input  logic                   clka,
    input  logic                   rsta,
    // Command and status
    input  logic                   cmd_valid,
    input  fill_pkg::fill_op_e     cmd_op,
    input  logic [`MEM_ADDR_W-1:0] cmd_base,
    input  logic [`MEM_ADDR_W:0]   cmd_len,      // 1 to MEM_DEPTH words
    input  logic [`MEM_DATA_W-1:0] cmd_pattern,
    output logic                   cmd_ready,
    output logic                   busy,
    output logic                   done,
    output logic [`MEM_DATA_W-1:0] sum_out,
    // Wishbone master, writes only
    output logic                   eng_cyc,
    output logic                   eng_stb,
    output logic                   eng_we,
    output logic [`MEM_ADDR_W-1:0] eng_adr,
    output logic [`MEM_SEL_W-1:0]  eng_sel,
    output logic [`MEM_DATA_W-1:0] eng_dat_w,
    input  logic                   eng_ack,
    // RAM port B, reads only
    output logic                   ram_b_en,
    output logic                   ram_b_we,
    output logic [`MEM_SEL_W-1:0]  ram_b_sel,
    output logic [`MEM_ADDR_W-1:0] ram_b_adr,
    output logic [`MEM_DATA_W-1:0] ram_b_dat_w,
    input  logic [`MEM_DATA_W-1:0] ram_b_dat_r
);

    import fill_pkg::*;

    fill_state_e            state;     // Engine FSM
    logic [`MEM_ADDR_W:0]   cnt;       // Words written or reads issued
    logic [`MEM_ADDR_W:0]   cnt_nxt;
    logic                   rd_vld;    // Port B data returns this cycle
    logic [`MEM_DATA_W-1:0] acc;       // Running sum
    logic                   accept;    // Command handshake
    logic [`MEM_ADDR_W-1:0] cur_adr;   // Base plus word offset, wraps at depth
    logic [`MEM_ADDR_W-1:0] base_r;    // Latched command fields
    logic [`MEM_ADDR_W:0]   len_r;
    logic [`MEM_DATA_W-1:0] pattern_r;

    assign cmd_ready = (state == fs_idle);
    assign busy      = (state != fs_idle);
    assign done      = (state == fs_done);
    assign sum_out   = acc;              // Holds until the next accepted command
    assign accept    = cmd_valid & cmd_ready;
    assign cnt_nxt   = cnt + 1'b1;
    assign cur_adr   = base_r + cnt[`MEM_ADDR_W-1:0];

    // Write request stays stable until its ack since cnt only moves on ack
    assign eng_cyc   = (state == fs_write);
    assign eng_stb   = eng_cyc;
    assign eng_we    = eng_cyc;
    assign eng_sel   = '1;               // Full words
    assign eng_adr   = cur_adr;
    assign eng_dat_w = pattern_r + {{(`MEM_DATA_W-`MEM_ADDR_W-1){1'b0}}, cnt};

    // One read per cycle until every word of the range is issued
    assign ram_b_en    = (state == fs_sum) && (cnt != len_r);
    assign ram_b_adr   = cur_adr;
    assign ram_b_we    = 1'b0;           // Port B write side unused
    assign ram_b_sel   = '0;
    assign ram_b_dat_w = '0;

    always_ff @(posedge clka) begin
        if (rsta) begin
            state  <= fs_idle;
            cnt    <= '0;
            rd_vld <= 1'b0;
            acc    <= '0;
        end else begin
            rd_vld <= ram_b_en;          // RAM read latency of one
            case (state)
                fs_idle: begin
                    if (accept) begin
                        cnt   <= '0;
                        acc   <= '0;
                        state <= (cmd_op == op_sum) ? fs_sum : fs_write;
                    end
                end
                fs_write: begin
                    if (eng_ack) begin
                        cnt <= cnt_nxt;
                        if (cnt_nxt == len_r)
                            state <= fs_done;    // Last write acknowledged
                    end
                end
                fs_sum: begin
                    if (ram_b_en)
                        cnt <= cnt_nxt;
                    if (rd_vld)
                        acc <= acc + ram_b_dat_r; // Wrapping 32-bit sum
                    if (cnt == len_r)
                        state <= fs_done;        // Last word added this cycle
                end
                fs_done: begin
                    state <= fs_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clka) begin
        if (accept) begin
            base_r    <= cmd_base;
            len_r     <= cmd_len;
            pattern_r <= cmd_pattern;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module mem_subsys_top (
    input  logic                   clka,
    input  logic                   rsta,
    // Host Wishbone classic slave
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`MEM_ADDR_W-1:0] wb_adr,
    input  logic [`MEM_SEL_W-1:0]  wb_sel,
    input  logic [`MEM_DATA_W-1:0] wb_dat_w,
    output logic [`MEM_DATA_W-1:0] wb_dat_r,
    output logic                   wb_ack,
    // Fill engine commands
    input  logic                   cmd_valid,
    input  fill_pkg::fill_op_e     cmd_op,
    input  logic [`MEM_ADDR_W-1:0] cmd_base,
    input  logic [`MEM_ADDR_W:0]   cmd_len,
    input  logic [`MEM_DATA_W-1:0] cmd_pattern,
    output logic                   cmd_ready,
    output logic                   busy,
    output logic                   done,
    output logic [`MEM_DATA_W-1:0] sum_out
);

    // Engine master into the arbiter
    logic                   eng_cyc;
    logic                   eng_stb;
    logic                   eng_we;
    logic [`MEM_ADDR_W-1:0] eng_adr;
    logic [`MEM_SEL_W-1:0]  eng_sel;
    logic [`MEM_DATA_W-1:0] eng_dat_w;
    logic                   eng_ack;

    // Arbiter to RAM port A
    logic                   ram_a_en;
    logic                   ram_a_we;
    logic [`MEM_SEL_W-1:0]  ram_a_sel;
    logic [`MEM_ADDR_W-1:0] ram_a_adr;
    logic [`MEM_DATA_W-1:0] ram_a_dat_w;
    logic [`MEM_DATA_W-1:0] ram_a_dat_r;

    // Engine to RAM port B
    logic                   ram_b_en;
    logic                   ram_b_we;
    logic [`MEM_SEL_W-1:0]  ram_b_sel;
    logic [`MEM_ADDR_W-1:0] ram_b_adr;
    logic [`MEM_DATA_W-1:0] ram_b_dat_w;
    logic [`MEM_DATA_W-1:0] ram_b_dat_r;

    wb_arbiter wb_arbiter_i (
        .clka        (clka),
        .rsta        (rsta),
        .m0_cyc      (wb_cyc),           // Host is master 0
        .m0_stb      (wb_stb),
        .m0_we       (wb_we),
        .m0_adr      (wb_adr),
        .m0_sel      (wb_sel),
        .m0_dat_w    (wb_dat_w),
        .m0_dat_r    (wb_dat_r),
        .m0_ack      (wb_ack),
        .m1_cyc      (eng_cyc),          // Fill engine is master 1
        .m1_stb      (eng_stb),
        .m1_we       (eng_we),
        .m1_adr      (eng_adr),
        .m1_sel      (eng_sel),
        .m1_dat_w    (eng_dat_w),
        .m1_dat_r    (),                 // Engine never reads over the bus
        .m1_ack      (eng_ack),
        .ram_a_en    (ram_a_en),
        .ram_a_we    (ram_a_we),
        .ram_a_sel   (ram_a_sel),
        .ram_a_adr   (ram_a_adr),
        .ram_a_dat_w (ram_a_dat_w),
        .ram_a_dat_r (ram_a_dat_r)
    );

    fill_engine fill_engine_i (
        .clka        (clka),
        .rsta        (rsta),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_base    (cmd_base),
        .cmd_len     (cmd_len),
        .cmd_pattern (cmd_pattern),
        .cmd_ready   (cmd_ready),
        .busy        (busy),
        .done        (done),
        .sum_out     (sum_out),
        .eng_cyc     (eng_cyc),
        .eng_stb     (eng_stb),
        .eng_we      (eng_we),
        .eng_adr     (eng_adr),
        .eng_sel     (eng_sel),
        .eng_dat_w   (eng_dat_w),
        .eng_ack     (eng_ack),
        .ram_b_en    (ram_b_en),
        .ram_b_we    (ram_b_we),
        .ram_b_sel   (ram_b_sel),
        .ram_b_adr   (ram_b_adr),
        .ram_b_dat_w (ram_b_dat_w),
        .ram_b_dat_r (ram_b_dat_r)
    );

    dpram #(
        .ram_width (`MEM_DATA_W),
        .ram_depth (`MEM_DEPTH)
    ) dpram_i (
        .clka  (clka),
        .ena   (ram_a_en),
        .wea   (ram_a_we),
        .wema  (ram_a_sel),
        .addra (ram_a_adr),
        .dina  (ram_a_dat_w),
        .douta (ram_a_dat_r),
        .enb   (ram_b_en),               // Summing read path
        .web   (ram_b_we),
        .wemb  (ram_b_sel),
        .addrb (ram_b_adr),
        .dinb  (ram_b_dat_w),
        .doutb (ram_b_dat_r)
    );

endmodule

`default_nettype wire

// ==== dv/mem_subsys_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assertions (
    input logic clka,
    input logic rsta,
    input logic m0_req,                 // cyc and stb of master 0
    input logic m0_ack,
    input logic m1_req,
    input logic m1_ack,
    input logic busy,
    input logic done,
    input logic cmd_ready
);

    logic [3:0] wait_m0;                // Cycles a held request has gone without ack
    logic [3:0] wait_m1;
    logic       fail_seen = 1'b0;       // Sticky, watched by the testbench

    always_ff @(posedge clka) begin
        wait_m0 <= (rsta || !m0_req || m0_ack) ? 4'd0 : wait_m0 + 4'd1;
        wait_m1 <= (rsta || !m1_req || m1_ack) ? 4'd0 : wait_m1 + 4'd1;
    end

    ack_with_req: assert property (@(posedge clka) disable iff (rsta)
        (!m0_ack || m0_req) && (!m1_ack || m1_req)) else begin
        $error("ack given without cyc and stb");
        fail_seen = 1'b1;
    end

    one_ack: assert property (@(posedge clka) disable iff (rsta) !(m0_ack && m1_ack)) else begin
        $error("both masters acknowledged in one cycle");
        fail_seen = 1'b1;
    end

    ack_in_time: assert property (@(posedge clka) disable iff (rsta)
        (wait_m0 <= 4'd4) && (wait_m1 <= 4'd4)) else begin
        $error("held request not acknowledged within 4 cycles");
        fail_seen = 1'b1;
    end

    done_pulse: assert property (@(posedge clka) disable iff (rsta) done |=> !done) else begin
        $error("done high for more than one cycle");
        fail_seen = 1'b1;
    end

    reset_state: assert property (@(posedge clka)
        rsta |=> (!m0_ack && !m1_ack && !m1_req && !busy && !done && cmd_ready)) else begin
        $error("control outputs active after reset");
        fail_seen = 1'b1;
    end

endmodule

bind wb_arbiter mem_subsys_assertions arb_assertions_i (
    .clka      (clka),
    .rsta      (rsta),
    .m0_req    (m0_cyc && m0_stb),
    .m0_ack    (m0_ack),
    .m1_req    (m1_cyc && m1_stb),
    .m1_ack    (m1_ack),
    .busy      (1'b0),                  // Engine status checked in the other instance
    .done      (1'b0),
    .cmd_ready (1'b1)
);

bind fill_engine mem_subsys_assertions eng_assertions_i (
    .clka      (clka),
    .rsta      (rsta),
    .m0_req    (1'b0),                  // Only the engine master is seen here
    .m0_ack    (1'b0),
    .m1_req    (eng_cyc && eng_stb),
    .m1_ack    (eng_ack),
    .busy      (busy),
    .done      (done),
    .cmd_ready (cmd_ready)
);

`default_nettype wire

// ==== dv/mem_subsys_tb.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"
`default_nettype none

module mem_subsys_tb;

    import fill_pkg::*;

    localparam int n_host = 32;                   // Random host writes in the first pass
    localparam int watchdog_cycles = 2 * (6 * `MEM_DEPTH + 16 * n_host + 1000);

    logic                   clka;
    logic                   rsta;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`MEM_ADDR_W-1:0] wb_adr;
    logic [`MEM_SEL_W-1:0]  wb_sel;
    logic [`MEM_DATA_W-1:0] wb_dat_w;
    logic [`MEM_DATA_W-1:0] wb_dat_r;
    logic                   wb_ack;
    logic                   cmd_valid;
    fill_op_e               cmd_op;
    logic [`MEM_ADDR_W-1:0] cmd_base;
    logic [`MEM_ADDR_W:0]   cmd_len;
    logic [`MEM_DATA_W-1:0] cmd_pattern;
    logic                   cmd_ready;
    logic                   busy;
    logic                   done;
    logic [`MEM_DATA_W-1:0] sum_out;

    logic [`MEM_DATA_W-1:0] shadow [`MEM_DEPTH];  // Expected RAM contents
    logic [`MEM_ADDR_W-1:0] adr_q [$];            // Host write addresses to read back
    logic [`MEM_DATA_W-1:0] host_rdat;            // Data of the last host access
    logic [31:0]            lfsr = 32'd4;
    logic                   arb_fail;
    logic                   eng_fail;

    assign arb_fail = mem_subsys_top_i.wb_arbiter_i.arb_assertions_i.fail_seen;
    assign eng_fail = mem_subsys_top_i.fill_engine_i.eng_assertions_i.fail_seen;

    mem_subsys_top mem_subsys_top_i (.*);

    initial begin
        clka = 1'b0;
        forever #2 clka = ~clka;                  // 4 ns period
    end

    // Galois LFSR, right shifting, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD000_0001 : 32'h0);
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            $display("TEST FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic host_access(input logic we, input logic [`MEM_ADDR_W-1:0] adr,
                               input logic [3:0] sel, input logic [31:0] dat);
        @(posedge clka);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_sel   <= sel;
        wb_dat_w <= dat;
        @(posedge clka);
        while (!wb_ack)
            @(posedge clka);                      // Request held until its ack
        host_rdat = wb_dat_r;
        wb_cyc    <= 1'b0;
        wb_stb    <= 1'b0;
    endtask

    task automatic host_write(input logic [`MEM_ADDR_W-1:0] adr, input logic [3:0] sel,
                              input logic [31:0] dat);
        host_access(1'b1, adr, sel, dat);
        for (int i = 0; i < 4; i++)
            if (sel[i])
                shadow[adr][i*8 +: 8] = dat[i*8 +: 8];   // Byte lane merge
    endtask

    task automatic host_read_check(input logic [`MEM_ADDR_W-1:0] adr);
        host_access(1'b0, adr, 4'h0, 32'h0);
        check_value("wb_dat_r", shadow[adr], host_rdat);
    endtask

    task automatic run_cmd(input fill_op_e op, input logic [`MEM_ADDR_W-1:0] base,
                           input logic [`MEM_ADDR_W:0] len, input logic [31:0] pat);
        logic [31:0]            exp_sum;
        logic [`MEM_ADDR_W-1:0] a;
        int                     cycles;
        exp_sum = '0;
        cycles  = 0;
        for (int i = 0; i < int'(len); i++) begin
            a = base + `MEM_ADDR_W'(i);           // Range wraps at the top of memory
            if (op == op_fill)
                shadow[a] = pat + 32'(i);
            else
                exp_sum = exp_sum + shadow[a];
        end
        @(posedge clka);
        cmd_valid   <= 1'b1;
        cmd_op      <= op;
        cmd_base    <= base;
        cmd_len     <= len;
        cmd_pattern <= pat;
        @(posedge clka);
        check_value("cmd_ready", 32'd1, 32'(cmd_ready));  // Accepted in the cycle just ended
        do begin                                  // Valid stays high as a refused second command
            @(posedge clka);
            cycles++;
            check_value("cmd_ready", 32'd0, 32'(cmd_ready));
            check_value("busy", 32'd1, 32'(busy));
        end while (!done);
        cmd_valid <= 1'b0;
        if (op == op_sum) begin
            check_value("sum_out", exp_sum, sum_out);
            check_value("done latency", 32'(len) + 32'd2, cycles);
        end
        @(posedge clka);
        check_value("busy", 32'd0, 32'(busy));
    endtask

    initial begin
        logic [`MEM_ADDR_W-1:0] a;
        logic [31:0]            r;
        logic [31:0]            pat;
        rsta        = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_sel      = '0;
        wb_dat_w    = '0;
        cmd_valid   = 1'b0;
        cmd_op      = op_fill;
        cmd_base    = '0;
        cmd_len     = '0;
        cmd_pattern = '0;
        repeat (3) @(posedge clka);
        rsta <= 1'b0;
        @(posedge clka);
        check_value("wb_ack", 32'd0, 32'(wb_ack));
        check_value("busy", 32'd0, 32'(busy));
        check_value("done", 32'd0, 32'(done));
        check_value("cmd_ready", 32'd1, 32'(cmd_ready));
        check_value("sum_out", 32'd0, sum_out);

        run_cmd(op_fill, '0, (`MEM_ADDR_W+1)'(`MEM_DEPTH), rand_bits(32));  // Known contents
        repeat (n_host) begin
            a = `MEM_ADDR_W'(rand_bits(10));
            host_write(a, 4'(rand_bits(4)), rand_bits(32));
            adr_q.push_back(a);
        end
        foreach (adr_q[i])
            host_read_check(adr_q[i]);

        run_cmd(op_fill, 10'd300, 11'd40, rand_bits(32));
        for (int i = 299; i <= 340; i++)
            host_read_check(`MEM_ADDR_W'(i));     // Range plus one word on each side

        run_cmd(op_sum, `MEM_ADDR_W'(rand_bits(10)), 11'(rand_bits(6)) + 11'd1, 32'd0);
        run_cmd(op_sum, 10'd1000, 11'd50, 32'd0);  // Wraps past the last word

        adr_q.delete();
        pat = rand_bits(32);
        fork
            run_cmd(op_fill, 10'd128, 11'd64, pat);
            repeat (16) begin                     // Upper half only, clear of the fill
                r = rand_bits(9);
                a = {1'b1, r[8:0]};
                host_write(a, 4'(rand_bits(4)), rand_bits(32));
                adr_q.push_back(a);
            end
        join
        for (int i = 127; i <= 192; i++)
            host_read_check(`MEM_ADDR_W'(i));
        foreach (adr_q[i])
            host_read_check(adr_q[i]);
        run_cmd(op_sum, '0, (`MEM_ADDR_W+1)'(`MEM_DEPTH), 32'd0);

        @(negedge clka);
        if (arb_fail || eng_fail) begin
            $display("A protocol assertion failed during the run");
            $display("TEST FAILED");
            $fatal(1, "Protocol assertion failure");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

    always @(negedge clka) begin
        if (arb_fail || eng_fail) begin
            $display("A protocol assertion failed at %0t", $time);
            $display("TEST FAILED");
            $fatal(1, "Protocol assertion failure");
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clka);  // Twice the expected run length
        $display("Watchdog expired, the DUT stopped responding");
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/wb_pkg.sv
common/fill_pkg.sv
memory/dpram.sv
logic/wb_arbiter.sv
logic/fill_engine.sv
logic/mem_subsys_top.sv
dv/mem_subsys_assertions.sv
dv/mem_subsys_tb.sv

// ==== run_verilator.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mem_subsys_tb -f tb.f -o mem_subsys_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mem_subsys_sim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
